// File: design/pw_defines.svh
`ifndef PW_DEFINES_SVH
`define PW_DEFINES_SVH

////////////////////
// sizes
////////////////////

`define PW_PATTERN_BYTES      8
`define PW_TRIG_DELAY_WIDTH   20
`define PW_TRIG_WIDTH_WIDTH   17

////////////////////
// register map
////////////////////

`define PW_ADDR_ARM       8'h00   // bit 0 armed, bit 1 triggered
`define PW_ADDR_SPEED     8'h01
`define PW_ADDR_PAT_LEN   8'h02
`define PW_ADDR_DELAY0    8'h03   // 3 bytes, lsb first
`define PW_ADDR_WIDTH0    8'h06   // 3 bytes, lsb first
`define PW_ADDR_PATTERN   8'h10   // 8 bytes
`define PW_ADDR_MASK      8'h18   // 8 bytes

// usb speed codes
`define PW_SPEED_LS       2'd0
`define PW_SPEED_FS       2'd1
`define PW_SPEED_HS       2'd2
`define PW_SPEED_AUTO     2'd3

`endif

// File: design/pw_pkg.sv
`default_nettype none

`include "pw_defines.svh"

package pw_pkg;

   ////////////////////
   // vector types
   ////////////////////

   typedef logic [7:0] addr_t;
   typedef logic [7:0] byte_t;
   typedef logic [1:0] speed_t;
   typedef logic [`PW_TRIG_DELAY_WIDTH-1:0] trig_delay_t;
   typedef logic [`PW_TRIG_WIDTH_WIDTH-1:0] trig_width_t;
   typedef logic [3:0] pat_len_t;   // 0 disables matching

   ////////////////////
   // bundles
   ////////////////////

   // utmi receive side, one byte per fe_clk
   typedef struct packed {
      byte_t data;
      logic  rxvalid;
      logic  rxactive;
   } fe_rx_t;

   // byte 0 of pattern and mask sits in the low bits
   typedef struct packed {
      logic [`PW_PATTERN_BYTES*8-1:0] pattern;
      logic [`PW_PATTERN_BYTES*8-1:0] mask;
      pat_len_t                       len;
   } pattern_cfg_t;

   typedef struct packed {
      trig_delay_t delay;
      trig_width_t width;
   } trig_cfg_t;

   typedef struct packed {
      logic [1:0] xcvrsel;
      logic       termsel;
   } phy_sel_t;

   typedef enum logic [1:0] {
      IDLE,
      DELAY,
      PULSE
   } trig_state_e;

endpackage

`default_nettype wire

// File: design/pw_registers.sv
`timescale 1ns/1ps
`default_nettype none

`include "pw_defines.svh"

module pw_registers (
   input  wire                   fe_clk,
   input  wire                   rst_n_i,
   input  pw_pkg::addr_t         usb_addr_i,
   input  pw_pkg::byte_t         usb_din_i,
   input  wire                   usb_ncs_i,
   input  wire                   usb_nrd_i,
   input  wire                   usb_nwe_i,
   input  wire                   match_i,
   output pw_pkg::byte_t         usb_dout_o,
   output logic                  usb_isout_o,
   output pw_pkg::pattern_cfg_t  pattern_cfg_o,
   output pw_pkg::trig_cfg_t     trig_cfg_o,
   output pw_pkg::phy_sel_t      phy_sel_o,
   output logic                  armed_o
);

   import pw_pkg::*;

   logic         wr;
   logic         rd;
   logic         pat_sel;
   logic         mask_sel;
   logic [2:0]   byte_idx;
   byte_t        rdata;

   speed_t       speed_q;
   pattern_cfg_t pat_q;
   trig_cfg_t    trig_q;
   logic         armed_q;
   logic         triggered_q;

   // strobes are active low
   assign wr = ~usb_ncs_i & ~usb_nwe_i;
   assign rd = ~usb_ncs_i & ~usb_nrd_i;

   assign pat_sel  = (usb_addr_i & 8'hF8) == `PW_ADDR_PATTERN;
   assign mask_sel = (usb_addr_i & 8'hF8) == `PW_ADDR_MASK;
   assign byte_idx = usb_addr_i[2:0];

   ////////////////////
   // config storage
   ////////////////////

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         speed_q <= `PW_SPEED_FS;
         pat_q   <= '0;
         trig_q  <= '0;
      end else if (wr) begin
         case (usb_addr_i)
            `PW_ADDR_SPEED:          speed_q       <= usb_din_i[1:0];
            `PW_ADDR_PAT_LEN:        pat_q.len     <= usb_din_i[3:0];
            `PW_ADDR_DELAY0:         trig_q.delay[7:0]  <= usb_din_i;
            `PW_ADDR_DELAY0 + 8'd1:  trig_q.delay[15:8] <= usb_din_i;
            `PW_ADDR_DELAY0 + 8'd2:
               trig_q.delay[`PW_TRIG_DELAY_WIDTH-1:16] <= usb_din_i[`PW_TRIG_DELAY_WIDTH-17:0];
            `PW_ADDR_WIDTH0:         trig_q.width[7:0]  <= usb_din_i;
            `PW_ADDR_WIDTH0 + 8'd1:  trig_q.width[15:8] <= usb_din_i;
            `PW_ADDR_WIDTH0 + 8'd2:
               trig_q.width[`PW_TRIG_WIDTH_WIDTH-1:16] <= usb_din_i[`PW_TRIG_WIDTH_WIDTH-17:0];
            default: begin
               if (pat_sel)
                  pat_q.pattern[byte_idx*8 +: 8] <= usb_din_i;
               if (mask_sel)
                  pat_q.mask[byte_idx*8 +: 8] <= usb_din_i;
            end
         endcase
      end
   end

   // host write wins over a match in the same cycle
   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         armed_q     <= 1'b0;
         triggered_q <= 1'b0;
      end else if (wr && usb_addr_i == `PW_ADDR_ARM) begin
         armed_q <= usb_din_i[0];
         if (usb_din_i[0])
            triggered_q <= 1'b0;   // re-arm clears old status
      end else if (match_i) begin
         armed_q     <= 1'b0;      // one shot
         triggered_q <= 1'b1;
      end
   end

   ////////////////////
   // readback
   ////////////////////

   always_comb begin
      rdata = '0;   // unmapped reads as zero
      case (usb_addr_i)
         `PW_ADDR_ARM:            rdata = {6'd0, triggered_q, armed_q};
         `PW_ADDR_SPEED:          rdata = {6'd0, speed_q};
         `PW_ADDR_PAT_LEN:        rdata = {4'd0, pat_q.len};
         `PW_ADDR_DELAY0:         rdata = trig_q.delay[7:0];
         `PW_ADDR_DELAY0 + 8'd1:  rdata = trig_q.delay[15:8];
         `PW_ADDR_DELAY0 + 8'd2:  rdata = byte_t'(trig_q.delay[`PW_TRIG_DELAY_WIDTH-1:16]);
         `PW_ADDR_WIDTH0:         rdata = trig_q.width[7:0];
         `PW_ADDR_WIDTH0 + 8'd1:  rdata = trig_q.width[15:8];
         `PW_ADDR_WIDTH0 + 8'd2:  rdata = byte_t'(trig_q.width[`PW_TRIG_WIDTH_WIDTH-1:16]);
         default: begin
            if (pat_sel)
               rdata = pat_q.pattern[byte_idx*8 +: 8];
            else if (mask_sel)
               rdata = pat_q.mask[byte_idx*8 +: 8];
         end
      endcase
   end

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         usb_isout_o <= 1'b0;
         usb_dout_o  <= '0;
      end else begin
         usb_isout_o <= rd;
         if (rd)
            usb_dout_o <= rdata;
      end
   end

   // phy speed select where auto falls back to full speed
   always_comb begin
      case (speed_q)
         `PW_SPEED_LS: phy_sel_o = '{xcvrsel: 2'b10, termsel: 1'b1};
         `PW_SPEED_HS: phy_sel_o = '{xcvrsel: 2'b00, termsel: 1'b0};
         `PW_SPEED_FS,
         `PW_SPEED_AUTO: phy_sel_o = '{xcvrsel: 2'b01, termsel: 1'b1};
      endcase
   end

   assign pattern_cfg_o = pat_q;
   assign trig_cfg_o    = trig_q;
   assign armed_o       = armed_q;

endmodule

`default_nettype wire

// File: design/pattern_matcher.sv
`timescale 1ns/1ps
`default_nettype none

`include "pw_defines.svh"

module pattern_matcher (
   input  wire                   fe_clk,
   input  wire                   rst_n_i,
   input  pw_pkg::fe_rx_t        fe_rx_i,
   input  pw_pkg::pattern_cfg_t  cfg_i,
   input  wire                   armed_i,
   output logic                  match_o
);

   import pw_pkg::*;

   localparam int IDX_W = $clog2(`PW_PATTERN_BYTES);

   pat_len_t         cnt_q;       // valid bytes seen in this packet
   logic             mismatch_q;  // sticky over the packet
   logic             in_window;
   logic [IDX_W-1:0] idx;
   byte_t            pat_byte;
   byte_t            mask_byte;
   logic             byte_bad;
   logic             byte_take;
   logic             last_byte;

   ////////////////////
   // compare
   ////////////////////

   assign in_window = cnt_q < pat_len_t'(`PW_PATTERN_BYTES);
   assign idx       = cnt_q[IDX_W-1:0];
   assign pat_byte  = cfg_i.pattern[idx*8 +: 8];
   assign mask_byte = cfg_i.mask[idx*8 +: 8];

   // mask bit 1 means compare
   assign byte_bad  = in_window & (|((fe_rx_i.data ^ pat_byte) & mask_byte));

   assign byte_take = fe_rx_i.rxactive & fe_rx_i.rxvalid;

   // this byte brings the count up to len
   assign last_byte = byte_take &
                      (cfg_i.len != '0) &
                      ((cnt_q + 4'd1) == cfg_i.len);

   ////////////////////
   // packet tracking
   ////////////////////

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q      <= '0;
         mismatch_q <= 1'b0;
      end else if (!fe_rx_i.rxactive) begin
         cnt_q      <= '0;          // between packets
         mismatch_q <= 1'b0;
      end else if (fe_rx_i.rxvalid) begin
         if (cnt_q != '1)
            cnt_q <= cnt_q + 4'd1;  // saturate, no wrap into a rematch
         mismatch_q <= mismatch_q | byte_bad;
      end
   end

   // registered, one cycle wide
   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i)
         match_o <= 1'b0;
      else
         match_o <= armed_i & last_byte & ~mismatch_q & ~byte_bad;
   end

endmodule

`default_nettype wire

// File: design/trigger_pulse.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_pulse (
   input  wire                 fe_clk,
   input  wire                 rst_n_i,
   input  wire                 match_i,
   input  pw_pkg::trig_cfg_t   cfg_i,
   output logic                trig_o,
   output logic                busy_o
);

   import pw_pkg::*;

   trig_state_e state_q;
   trig_delay_t cnt_q;     // shared by delay and pulse phases
   trig_delay_t delay_q;
   trig_width_t width_q;

   ////////////////////
   // fsm
   ////////////////////

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               // zero width means no pulse at all
               if (match_i && cfg_i.width != '0) begin
                  state_q <= DELAY;
                  cnt_q   <= '0;
               end
            end
            DELAY: begin
               if (cnt_q == delay_q) begin
                  state_q <= PULSE;
                  cnt_q   <= trig_delay_t'(1);
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            PULSE: begin
               if (cnt_q == trig_delay_t'(width_q))
                  state_q <= IDLE;
               else
                  cnt_q <= cnt_q + 1'b1;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // snapshot at the match, later writes don't disturb this pulse
   always_ff @(posedge fe_clk) begin
      if (state_q == IDLE && match_i) begin
         delay_q <= cfg_i.delay;
         width_q <= cfg_i.width;
      end
   end

   assign trig_o = (state_q == PULSE);
   assign busy_o = (state_q != IDLE);   // matches ignored while set

endmodule

`default_nettype wire

// File: design/phywhisperer_top.sv
`timescale 1ns/1ps
`default_nettype none

module phywhisperer_top (
   input  wire             fe_clk,
   input  wire             rst_n_i,

   // host register bus
   input  pw_pkg::addr_t   usb_addr_i,
   input  pw_pkg::byte_t   usb_din_i,
   input  wire             usb_ncs_i,
   input  wire             usb_nrd_i,
   input  wire             usb_nwe_i,
   output pw_pkg::byte_t   usb_dout_o,
   output logic            usb_isout_o,   // host drives the pad from this

   // utmi front end
   input  pw_pkg::byte_t   fe_data_i,
   input  wire             fe_rxvalid_i,
   input  wire             fe_rxactive_i,
   output logic [1:0]      fe_xcvrsel_o,
   output logic            fe_termsel_o,

   output logic            cw_trig_o,
   output logic            led_cap_o,
   output logic            led_trig_o
);

   import pw_pkg::*;

   fe_rx_t       fe_rx;
   pattern_cfg_t pattern_cfg;
   trig_cfg_t    trig_cfg;
   phy_sel_t     phy_sel;
   logic         armed;
   logic         match;
   logic         trig_busy;

   assign fe_rx = '{data: fe_data_i, rxvalid: fe_rxvalid_i, rxactive: fe_rxactive_i};

   pw_registers pw_registers_i (
      .fe_clk        (fe_clk),
      .rst_n_i       (rst_n_i),
      .usb_addr_i    (usb_addr_i),
      .usb_din_i     (usb_din_i),
      .usb_ncs_i     (usb_ncs_i),
      .usb_nrd_i     (usb_nrd_i),
      .usb_nwe_i     (usb_nwe_i),
      .match_i       (match),
      .usb_dout_o    (usb_dout_o),
      .usb_isout_o   (usb_isout_o),
      .pattern_cfg_o (pattern_cfg),
      .trig_cfg_o    (trig_cfg),
      .phy_sel_o     (phy_sel),
      .armed_o       (armed)
   );

   pattern_matcher pattern_matcher_i (
      .fe_clk   (fe_clk),
      .rst_n_i  (rst_n_i),
      .fe_rx_i  (fe_rx),
      .cfg_i    (pattern_cfg),
      .armed_i  (armed),
      .match_o  (match)
   );

   trigger_pulse trigger_pulse_i (
      .fe_clk   (fe_clk),
      .rst_n_i  (rst_n_i),
      .match_i  (match),
      .cfg_i    (trig_cfg),
      .trig_o   (cw_trig_o),
      .busy_o   (trig_busy)
   );

   assign fe_xcvrsel_o = phy_sel.xcvrsel;
   assign fe_termsel_o = phy_sel.termsel;
   assign led_cap_o    = armed;
   assign led_trig_o   = trig_busy;

endmodule

`default_nettype wire

// File: verification/tb_phywhisperer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pw_defines.svh"

module tb_phywhisperer;

   import pw_pkg::*;

   localparam int RST_CYCLES    = 8;
   localparam int NUM_TESTS     = 6;
   localparam int CFG_CYCLES    = 32;   // full register load over the bus
   localparam int PKT_CYCLES    = 16;   // idle, lead-in, bytes and gaps
   localparam int WIN_CYCLES    = 16;   // longest delay + width used here
   localparam int PKTS_PER_TEST = 3;
   localparam int TEST_CYCLES   = 2 * CFG_CYCLES + PKTS_PER_TEST * (PKT_CYCLES + WIN_CYCLES + 4);
   localparam int MAX_CYCLES    = RST_CYCLES + NUM_TESTS * TEST_CYCLES;

   logic       fe_clk = 1'b0;
   logic       rst_n;
   addr_t      usb_addr;
   byte_t      usb_din;
   byte_t      usb_dout;
   byte_t      fe_data;
   logic       usb_ncs, usb_nrd, usb_nwe, usb_isout;
   logic       fe_rxvalid, fe_rxactive, fe_termsel;
   logic [1:0] fe_xcvrsel;
   logic       cw_trig, led_cap, led_trig;

   // expected register state
   byte_t      pat_ref [`PW_PATTERN_BYTES];
   byte_t      mask_ref [`PW_PATTERN_BYTES];
   pat_len_t   len_ref;
   int         delay_ref, width_ref;
   logic       armed_ref, triggered_ref;

   byte_t       pkt_q [$];
   logic [31:0] lfsr_q;
   int          cycle_cnt = 0;
   int          errors, checks, tests, test_errors;
   string       test_name;

   phywhisperer_top phywhisperer_top_i (
      .fe_clk        (fe_clk),
      .rst_n_i       (rst_n),
      .usb_addr_i    (usb_addr),
      .usb_din_i     (usb_din),
      .usb_ncs_i     (usb_ncs),
      .usb_nrd_i     (usb_nrd),
      .usb_nwe_i     (usb_nwe),
      .usb_dout_o    (usb_dout),
      .usb_isout_o   (usb_isout),
      .fe_data_i     (fe_data),
      .fe_rxvalid_i  (fe_rxvalid),
      .fe_rxactive_i (fe_rxactive),
      .fe_xcvrsel_o  (fe_xcvrsel),
      .fe_termsel_o  (fe_termsel),
      .cw_trig_o     (cw_trig),
      .led_cap_o     (led_cap),
      .led_trig_o    (led_trig)
   );

   always #50 fe_clk = ~fe_clk;   // 100 ns period

   always @(posedge fe_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Test FAILED");
         $finish;
      end
   end

   ////////////////////
   // compare tasks
   ////////////////////

   task automatic check_byte(input byte_t got, input byte_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
      end
   endtask

   task automatic check_phy(input phy_sel_t got, input phy_sel_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s is xcvrsel %b termsel %b, expected %b %b",
                  $time, what, got.xcvrsel, got.termsel, exp.xcvrsel, exp.termsel);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   ////////////////////
   // stimulus helpers
   ////////////////////

   // galois form with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   task automatic rand_byte(output byte_t b);
      b = '0;
      for (int i = 0; i < 8; i++) begin
         b = {b[6:0], lfsr_q[0]};   // one step per bit
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   // bits of a 3-byte register that live in its top byte
   function automatic byte_t top_byte_mask(input int bits);
      return byte_t'((1 << (bits - 16)) - 1);
   endfunction

   task automatic bus_write(input addr_t addr, input byte_t data);
      usb_addr = addr;
      usb_din  = data;
      usb_ncs  = 1'b0;
      usb_nwe  = 1'b0;
      @(posedge fe_clk);
      #1;
      usb_ncs = 1'b1;
      usb_nwe = 1'b1;
      check_bit(usb_isout, 1'b0, "usb_isout_o after write");
   endtask

   task automatic bus_read(input addr_t addr, output byte_t data);
      usb_addr = addr;
      usb_ncs  = 1'b0;
      usb_nrd  = 1'b0;
      @(posedge fe_clk);
      #1;
      usb_ncs = 1'b1;
      usb_nrd = 1'b1;
      check_bit(usb_isout, 1'b1, "usb_isout_o during read");
      data = usb_dout;
   endtask

   task automatic configure(input int len, input int delay, input int width);
      bus_write(`PW_ADDR_PAT_LEN, byte_t'(len));
      for (int i = 0; i < 3; i++) begin
         bus_write(`PW_ADDR_DELAY0 + addr_t'(i), byte_t'(delay >> (8 * i)));
         bus_write(`PW_ADDR_WIDTH0 + addr_t'(i), byte_t'(width >> (8 * i)));
      end
      len_ref   = pat_len_t'(len);
      delay_ref = delay;
      width_ref = width;
   endtask

   task automatic load_pattern();
      for (int i = 0; i < `PW_PATTERN_BYTES; i++) begin
         bus_write(`PW_ADDR_PATTERN + addr_t'(i), pat_ref[i]);
         bus_write(`PW_ADDR_MASK + addr_t'(i), mask_ref[i]);
      end
   endtask

   task automatic set_arm(input logic arm);
      bus_write(`PW_ADDR_ARM, {7'd0, arm});
      armed_ref = arm;
      if (arm)
         triggered_ref = 1'b0;
   endtask

   // compared bits come from the pattern and the rest are random
   task automatic fill_packet(input int n);
      byte_t r;
      pkt_q.delete();
      for (int i = 0; i < n; i++) begin
         rand_byte(r);
         pkt_q.push_back((pat_ref[i] & mask_ref[i]) | (r & ~mask_ref[i]));
      end
   endtask

   // returns just after the edge that samples the last byte
   task automatic send_packet(input int gap_at, input int gap_len);
      fe_rxactive = 1'b0;   // idle edge marks the packet boundary
      fe_rxvalid  = 1'b0;
      @(posedge fe_clk);
      #1;
      fe_rxactive = 1'b1;
      @(posedge fe_clk);
      #1;
      foreach (pkt_q[i]) begin
         if (i == gap_at) begin
            fe_rxvalid = 1'b0;
            repeat (gap_len) begin
               @(posedge fe_clk);
               #1;
            end
         end
         fe_data    = pkt_q[i];
         fe_rxvalid = 1'b1;
         @(posedge fe_clk);
         #1;
      end
      fe_rxactive = 1'b0;
      fe_rxvalid  = 1'b0;
   endtask

   function automatic logic expect_match();
      if (!armed_ref || len_ref == '0 || pkt_q.size() < int'(len_ref))
         return 1'b0;
      for (int i = 0; i < int'(len_ref); i++)
         if (((pkt_q[i] ^ pat_ref[i]) & mask_ref[i]) != 8'h00)
            return 1'b0;
      return 1'b1;
   endfunction

   // k counts edges after the one that sampled byte len
   task automatic watch_trigger();
      logic matched;
      logic pulse;
      int   span;
      matched = expect_match();
      pulse   = matched && width_ref != 0;
      if (matched) begin
         armed_ref     = 1'b0;
         triggered_ref = 1'b1;
      end
      span = delay_ref + width_ref + 3;
      for (int k = 1; k <= span; k++) begin
         @(posedge fe_clk);
         #1;
         check_bit(cw_trig, pulse && k >= delay_ref + 2 && k < delay_ref + 2 + width_ref,
                   $sformatf("cw_trig_o %0d cycles after last byte", k));
         check_bit(led_trig, pulse && k <= delay_ref + 1 + width_ref, "led_trig_o");
      end
      check_bit(led_cap, armed_ref, "led_cap_o after packet");
   endtask

   task automatic read_status();
      byte_t st;
      bus_read(`PW_ADDR_ARM, st);
      check_byte(st, {6'd0, triggered_ref, armed_ref}, "arm/status register");
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = errors;
      tests++;
   endtask

   task automatic end_test();
      $display("%s: %s", test_name, (errors == test_errors) ? "passed" : "failed");
   endtask

   ////////////////////
   // directed tests
   ////////////////////

   task automatic register_readback();
      byte_t rd;
      addr_t unmapped [4];
      begin_test("register readback");
      unmapped = '{8'h09, 8'h0F, 8'h20, 8'hFF};
      check_phy(phy_sel_t'({fe_xcvrsel, fe_termsel}), '{xcvrsel: 2'b01, termsel: 1'b1},
                "phy select after reset");
      check_bit(cw_trig, 1'b0, "cw_trig_o after reset");
      check_bit(led_cap, 1'b0, "led_cap_o after reset");
      check_bit(led_trig, 1'b0, "led_trig_o after reset");
      check_bit(usb_isout, 1'b0, "usb_isout_o after reset");
      bus_read(`PW_ADDR_ARM, rd);
      check_byte(rd, 8'h00, "status after reset");
      bus_write(`PW_ADDR_SPEED, {6'd0, `PW_SPEED_HS});
      bus_write(`PW_ADDR_DELAY0, 8'h34);
      bus_write(`PW_ADDR_DELAY0 + 8'd1, 8'h12);
      bus_write(`PW_ADDR_DELAY0 + 8'd2, 8'hAB);
      bus_write(`PW_ADDR_WIDTH0, 8'h78);
      bus_write(`PW_ADDR_WIDTH0 + 8'd1, 8'h56);
      bus_write(`PW_ADDR_WIDTH0 + 8'd2, 8'hFF);
      bus_write(`PW_ADDR_PAT_LEN, 8'hF7);   // 4-bit field
      for (int i = 0; i < `PW_PATTERN_BYTES; i++) begin
         rand_byte(pat_ref[i]);
         rand_byte(mask_ref[i]);
      end
      load_pattern();
      bus_read(`PW_ADDR_SPEED, rd);
      check_byte(rd, {6'd0, `PW_SPEED_HS}, "speed");
      bus_read(`PW_ADDR_DELAY0, rd);
      check_byte(rd, 8'h34, "delay byte 0");
      bus_read(`PW_ADDR_DELAY0 + 8'd1, rd);
      check_byte(rd, 8'h12, "delay byte 1");
      bus_read(`PW_ADDR_DELAY0 + 8'd2, rd);
      check_byte(rd, 8'hAB & top_byte_mask(`PW_TRIG_DELAY_WIDTH), "delay byte 2");
      bus_read(`PW_ADDR_WIDTH0, rd);
      check_byte(rd, 8'h78, "width byte 0");
      bus_read(`PW_ADDR_WIDTH0 + 8'd1, rd);
      check_byte(rd, 8'h56, "width byte 1");
      bus_read(`PW_ADDR_WIDTH0 + 8'd2, rd);
      check_byte(rd, 8'hFF & top_byte_mask(`PW_TRIG_WIDTH_WIDTH), "width byte 2");
      bus_read(`PW_ADDR_PAT_LEN, rd);
      check_byte(rd, 8'h07, "pattern length");
      for (int i = 0; i < `PW_PATTERN_BYTES; i++) begin
         bus_read(`PW_ADDR_PATTERN + addr_t'(i), rd);
         check_byte(rd, pat_ref[i], $sformatf("pattern byte %0d", i));
         bus_read(`PW_ADDR_MASK + addr_t'(i), rd);
         check_byte(rd, mask_ref[i], $sformatf("mask byte %0d", i));
      end
      foreach (unmapped[i]) begin
         bus_read(unmapped[i], rd);
         check_byte(rd, 8'h00, $sformatf("unmapped address 0x%02h", unmapped[i]));
      end
      end_test();
   endtask

   task automatic speed_decode();
      phy_sel_t exp;
      begin_test("speed decode");
      for (int s = 0; s < 4; s++) begin
         bus_write(`PW_ADDR_SPEED, byte_t'(s));
         case (speed_t'(s))
            `PW_SPEED_LS: exp = '{xcvrsel: 2'b10, termsel: 1'b1};
            `PW_SPEED_HS: exp = '{xcvrsel: 2'b00, termsel: 1'b0};
            default:      exp = '{xcvrsel: 2'b01, termsel: 1'b1};   // fs and auto
         endcase
         check_phy(phy_sel_t'({fe_xcvrsel, fe_termsel}), exp, $sformatf("speed code %0d", s));
      end
      bus_write(`PW_ADDR_SPEED, {6'd0, `PW_SPEED_FS});
      end_test();
   endtask

   task automatic exact_match();
      begin_test("exact match and trigger timing");
      for (int i = 0; i < `PW_PATTERN_BYTES; i++) begin
         rand_byte(pat_ref[i]);
         mask_ref[i] = 8'hFF;
      end
      load_pattern();
      configure(4, 3, 2);
      set_arm(1'b1);
      read_status();
      check_bit(led_cap, 1'b1, "led_cap_o when armed");
      fill_packet(4);
      send_packet(-1, 0);
      watch_trigger();
      read_status();
      end_test();
   endtask

   task automatic masked_bytes();
      begin_test("masked bytes");
      mask_ref = '{8'hF0, 8'h0F, 8'h00, 8'h3C, 8'hFF, 8'hFF, 8'hFF, 8'hFF};
      load_pattern();
      configure(4, 1, 3);
      set_arm(1'b1);
      fill_packet(4);
      send_packet(-1, 0);
      watch_trigger();
      read_status();
      set_arm(1'b1);
      fill_packet(4);
      pkt_q[3] = pkt_q[3] ^ 8'h04;   // bit 2 is compared in byte 3
      send_packet(-1, 0);
      watch_trigger();
      read_status();
      set_arm(1'b0);
      end_test();
   endtask

   task automatic packet_boundaries();
      begin_test("packet boundaries");
      for (int i = 0; i < `PW_PATTERN_BYTES; i++)
         mask_ref[i] = 8'hFF;
      load_pattern();
      configure(5, 2, 2);
      set_arm(1'b1);
      fill_packet(4);       // one byte short
      send_packet(-1, 0);
      watch_trigger();
      read_status();
      fill_packet(5);
      send_packet(2, 3);    // rxvalid gap mid packet
      watch_trigger();
      read_status();
      fill_packet(5);       // not re-armed
      send_packet(-1, 0);
      watch_trigger();
      read_status();
      end_test();
   endtask

   task automatic pulse_edge_cases();
      begin_test("pulse edge cases");
      configure(5, 2, 0);
      set_arm(1'b1);
      fill_packet(5);
      send_packet(-1, 0);
      watch_trigger();
      read_status();
      configure(5, 0, 2);
      set_arm(1'b1);
      fill_packet(5);
      send_packet(-1, 0);
      watch_trigger();
      read_status();
      end_test();
   endtask

   initial begin
      $timeformat(-9, 0, " ns", 0);
      rst_n         = 1'b0;
      usb_addr      = '0;
      usb_din       = '0;
      usb_ncs       = 1'b1;
      usb_nrd       = 1'b1;
      usb_nwe       = 1'b1;
      fe_data       = '0;
      fe_rxvalid    = 1'b0;
      fe_rxactive   = 1'b0;
      lfsr_q        = 32'h9627;
      errors        = 0;
      checks        = 0;
      tests         = 0;
      len_ref       = '0;
      delay_ref     = 0;
      width_ref     = 0;
      armed_ref     = 1'b0;
      triggered_ref = 1'b0;
      repeat (RST_CYCLES) @(posedge fe_clk);
      #1;
      rst_n = 1'b1;

      register_readback();
      speed_decode();
      exact_match();
      masked_bytes();
      packet_boundaries();
      pulse_edge_cases();

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/pw_pkg.sv
design/pw_registers.sv
design/pattern_matcher.sv
design/trigger_pulse.sv
design/phywhisperer_top.sv
verification/tb_phywhisperer.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0 -Wno-fatal
TOP       = tb_phywhisperer
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
